/* Makefile */
# Verilator build for the register bank testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_regbank
FILELIST  = all.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = ERRORS FOUND

SOURCES = $(wildcard hw/*.sv) $(wildcard dv/*.sv) $(wildcard dv/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; \
	status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	   echo "simulation failed, see $(LOG)"; \
	   exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
hw/regbank_cfg_pkg.sv
hw/cpu_bus_pkg.sv
hw/regbank_wr_if.sv
hw/strb_offset.sv
hw/cpu_wr_port.sv
hw/regbank_2p.sv
hw/regbank_top.sv
+incdir+dv
dv/tb_regbank.sv

/* dv/regbank_model.svh */
`ifndef REGBANK_MODEL_SVH
`define REGBANK_MODEL_SVH

// reference register bank, included into tb_regbank
// the stage variables mirror the one-cycle cpu request register

reg_byte_t model_regs [REG_N];  // expected register contents
logic      stage_wen;           // also the expected cpu_ack_o
waddr_t    stage_addr;
wstrb_t    stage_strb;
wdata_t    stage_data;

// zero bits below the lowest strobe bit, STRB_W when empty
function automatic int trailing_zeros(input wstrb_t strb);
   int n;
   n = 0;
   while (n < STRB_W && !strb[n]) begin
      n++;
   end
   return n;
endfunction

// one byte per request, at word address plus lane
task automatic apply_write(input waddr_t addr, input wstrb_t strb, input wdata_t data);
   int lane;
   int target;
   lane   = trailing_zeros(strb);
   target = int'(addr) + lane;
   if (lane < STRB_W && target < REG_N) begin
      model_regs[target] = data[REG_W*lane +: REG_W];
   end
endtask

task automatic clear_model();
   for (int i = 0; i < REG_N; i++) begin
      model_regs[i] = '0;
   end
   stage_wen = 1'b0;
endtask

// one rising edge, with the inputs the DUT samples there
task automatic advance_edge(input logic rst, input logic cke, input logic valid,
                            input waddr_t addr, input wstrb_t strb, input wdata_t data);
   if (rst) begin
      clear_model();
   end else if (cke) begin
      if (stage_wen) begin
         apply_write(stage_addr, stage_strb, stage_data);  // request from last edge
      end
      stage_wen = valid;
      if (valid) begin
         stage_addr = addr;
         stage_strb = strb;
         stage_data = data;
      end
   end
endtask

// four registers from start, start in the low byte
function automatic rdata_t expected_window(input int start);
   rdata_t w;
   w = '0;
   for (int k = 0; k < RD_REGS; k++) begin
      w[k*REG_W +: REG_W] = model_regs[start + k];
   end
   return w;
endfunction

`endif

/* dv/tb_regbank.sv */
`timescale 1ns/1ps

module tb_regbank
   import regbank_cfg_pkg::*;
   import cpu_bus_pkg::*;
();

   localparam int SEED_INIT = 32'hba04f2aa;
   localparam int RESET_CYC = 2;
   localparam int T1_CYC    = 8;    // reset state
   localparam int T2_CYC    = 400;  // single lane writes
   localparam int T3_CYC    = 400;  // multi-bit strobes
   localparam int T4_CYC    = 300;  // back-to-back requests
   localparam int T5_CYC    = 500;  // clock enable stretches
   localparam int T6_CYC    = 400;  // random reads
   localparam int DRAIN_CYC = 6;
   localparam int TOTAL_CYC = RESET_CYC + T1_CYC + T2_CYC + T3_CYC + T4_CYC
                              + T5_CYC + T6_CYC + DRAIN_CYC;
   localparam int TIMEOUT_CYC = TOTAL_CYC * 3 / 2;

   logic     clk_i;
   logic     reset_i;
   logic     cke_i;
   logic     cpu_valid_i;
   waddr_t   cpu_addr_i;
   wdata_t   cpu_wdata_i;
   wstrb_t   cpu_wstrb_i;
   logic     cpu_ack_o;
   reg_idx_t raddr_i;
   rdata_t   rdata_o;

   int seed        = SEED_INIT;
   int error_count = 0;
   int cycle_count = 0;

   `include "regbank_model.svh"

   regbank_top u_dut (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .cke_i       (cke_i),
      .cpu_valid_i (cpu_valid_i),
      .cpu_addr_i  (cpu_addr_i),
      .cpu_wdata_i (cpu_wdata_i),
      .cpu_wstrb_i (cpu_wstrb_i),
      .cpu_ack_o   (cpu_ack_o),
      .raddr_i     (raddr_i),
      .rdata_o     (rdata_o)
   );

   initial clk_i = 1'b0;
   always #4 clk_i = ~clk_i;  // 8 ns period

   // model sees the same inputs as the DUT at each edge
   always @(posedge clk_i) begin
      advance_edge(reset_i, cke_i, cpu_valid_i, cpu_addr_i, cpu_wstrb_i, cpu_wdata_i);
   end

   // compare on the falling edge, outputs settled
   always @(negedge clk_i) begin
      rdata_t exp_rdata;
      if (!reset_i) begin
         exp_rdata = expected_window(int'(raddr_i));
         if (cpu_ack_o !== stage_wen) begin
            $display("[ERROR] cpu_ack_o expected 0x%0h got 0x%0h at cycle %0d",
                     stage_wen, cpu_ack_o, cycle_count);
            error_count++;
         end
         if (rdata_o !== exp_rdata) begin
            $display("[ERROR] rdata_o expected 0x%08h got 0x%08h (raddr_i 0x%0h) at cycle %0d",
                     exp_rdata, rdata_o, raddr_i, cycle_count);
            error_count++;
         end
      end
   end

   always @(posedge clk_i) begin
      cycle_count++;
      if (cycle_count > TIMEOUT_CYC) begin
         $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   function automatic logic [31:0] next_rand();
      return $random(seed);
   endfunction

   function automatic waddr_t pick_word_addr();
      logic [31:0] r;
      r = next_rand();
      return {r[3:2], 2'b00};  // word aligned
   endfunction

   function automatic wstrb_t one_hot_strobe();
      logic [31:0] r;
      r = next_rand();
      return wstrb_t'(1) << r[1:0];
   endfunction

   // at least min_bits strobe bits set
   function automatic wstrb_t strobe_with_bits(input int min_bits);
      logic [31:0] r;
      r = next_rand();
      while ($countones(r[3:0]) < min_bits) begin
         r = next_rand();
      end
      return r[3:0];
   endfunction

   task automatic drive_cycle(input logic cke, input logic valid, input waddr_t addr,
                              input wdata_t data, input wstrb_t strb, input reg_idx_t raddr);
      @(posedge clk_i);
      cke_i       <= cke;
      cpu_valid_i <= valid;
      cpu_addr_i  <= addr;
      cpu_wdata_i <= data;
      cpu_wstrb_i <= strb;
      raddr_i     <= raddr;
   endtask

   task automatic report_test(input int num, input string name, input int errs_before);
      $display("test %0d %s: %0d errors", num, name, error_count - errs_before);
   endtask

   task automatic check_reset_state();
      int errs_before;
      errs_before = error_count;
      for (int i = 0; i < T1_CYC; i++) begin
         drive_cycle(1'b1, 1'b0, '0, '0, '0, reg_idx_t'((i % 4) * 4));
         @(negedge clk_i);
         if (rdata_o !== '0) begin
            $display("[ERROR] rdata_o expected 0x00000000 got 0x%08h after reset", rdata_o);
            error_count++;
         end
         if (cpu_ack_o !== 1'b0) begin
            $display("[ERROR] cpu_ack_o expected 0x0 got 0x%0h after reset", cpu_ack_o);
            error_count++;
         end
      end
      report_test(1, "reset state", errs_before);
   endtask

   // one strobe bit per request, read index sweeps 0 to 12
   task automatic write_single_lanes();
      int          errs_before;
      logic [31:0] r;
      errs_before = error_count;
      for (int i = 0; i < T2_CYC; i++) begin
         r = next_rand();
         drive_cycle(1'b1, r[0], pick_word_addr(), next_rand(), one_hot_strobe(),
                     reg_idx_t'(i % 13));
      end
      report_test(2, "single lane writes", errs_before);
   endtask

   task automatic write_multi_strobes();
      int          errs_before;
      logic [31:0] r;
      errs_before = error_count;
      for (int i = 0; i < T3_CYC; i++) begin
         r = next_rand();
         drive_cycle(1'b1, r[0], pick_word_addr(), next_rand(), strobe_with_bits(2),
                     reg_idx_t'(i % 13));
      end
      report_test(3, "multi-bit strobes", errs_before);
   endtask

   // mostly valid, so many requests come back to back
   task automatic stream_back_to_back();
      int          errs_before;
      logic [31:0] r;
      errs_before = error_count;
      for (int i = 0; i < T4_CYC; i++) begin
         r = next_rand();
         drive_cycle(1'b1, r[1:0] != 2'b00, pick_word_addr(), next_rand(),
                     strobe_with_bits(1), r[7:4] % 4'd13);
      end
      report_test(4, "back-to-back requests", errs_before);
   endtask

   task automatic toggle_clock_enable();
      int          errs_before;
      int          stretch;
      logic        cke;
      logic [31:0] r;
      errs_before = error_count;
      stretch     = 0;
      cke         = 1'b1;
      for (int i = 0; i < T5_CYC; i++) begin
         r = next_rand();
         if (stretch == 0) begin
            cke     = ~cke;
            stretch = 1 + int'(r[10:8]);  // 1 to 8 cycles per level
         end
         stretch--;
         drive_cycle(cke, r[0], pick_word_addr(), next_rand(), strobe_with_bits(1),
                     r[7:4] % 4'd13);
      end
      report_test(5, "clock enable stretches", errs_before);
   endtask

   task automatic read_between_writes();
      int          errs_before;
      logic [31:0] r;
      errs_before = error_count;
      for (int i = 0; i < T6_CYC; i++) begin
         r = next_rand();
         drive_cycle(1'b1, r[1:0] == 2'b00, pick_word_addr(), next_rand(),
                     strobe_with_bits(1), r[7:4] % 4'd13);
      end
      report_test(6, "random reads", errs_before);
   endtask

   initial begin
      reset_i     = 1'b1;
      cke_i       = 1'b1;
      cpu_valid_i = 1'b0;
      cpu_addr_i  = '0;
      cpu_wdata_i = '0;
      cpu_wstrb_i = '0;
      raddr_i     = '0;
      repeat (RESET_CYC) @(posedge clk_i);
      reset_i <= 1'b0;

      check_reset_state();
      write_single_lanes();
      write_multi_strobes();
      stream_back_to_back();
      toggle_clock_enable();
      read_between_writes();

      // let the last requests retire and get checked
      for (int i = 0; i < DRAIN_CYC; i++) begin
         drive_cycle(1'b1, 1'b0, '0, '0, '0, reg_idx_t'((i % 4) * 4));
      end
      @(negedge clk_i);
      @(posedge clk_i);

      $display("summary: %0d errors in 6 tests over %0d cycles", error_count, cycle_count);
      if (error_count == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

/* hw/cpu_bus_pkg.sv */
package cpu_bus_pkg;

   // cpu write bus widths
   localparam int DATA_W  = 32;           // write data
   localparam int STRB_W  = DATA_W / 8;   // one strobe bit per byte lane
   localparam int WADDR_W = 4;            // byte address, word aligned

   // lane offset must also hold STRB_W itself
   // (the count for an empty strobe)
   localparam int LANE_W  = $clog2(STRB_W) + 1;

   typedef logic [DATA_W-1:0]  wdata_t;
   typedef logic [STRB_W-1:0]  wstrb_t;
   typedef logic [WADDR_W-1:0] waddr_t;
   typedef logic [LANE_W-1:0]  lane_t;

endpackage

/* hw/cpu_wr_port.sv */
`timescale 1ns/1ps

// cpu write request stage
// one register between the cpu strobes and the register file
module cpu_wr_port
   import cpu_bus_pkg::*;
(
   input  logic   clk_i,
   input  logic   reset_i,
   input  logic   cke_i,
   input  logic   valid_i,
   input  waddr_t addr_i,
   input  wdata_t wdata_i,
   input  wstrb_t wstrb_i,
   output logic   ack_o,
   regbank_wr_if.source wr
);

   logic   wen_q;    // request held for the register file
   waddr_t waddr_q;
   wstrb_t wstrb_q;
   wdata_t wdata_q;

   // control flop follows valid_i on every enabled edge
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wen_q <= 1'b0;
      end else if (cke_i) begin
         wen_q <= valid_i;
      end
   end

   // payload only moves when a request arrives
   always_ff @(posedge clk_i) begin
      if (cke_i && valid_i) begin
         waddr_q <= addr_i;
         wstrb_q <= wstrb_i;
         wdata_q <= wdata_i;
      end
   end

   assign wr.wen   = wen_q;
   assign wr.waddr = waddr_q;
   assign wr.wstrb = wstrb_q;
   assign wr.wdata = wdata_q;

   // one-cycle ack in the cycle the request sits on the interface
   assign ack_o = wen_q;

   // accepted request reaches the bank word aligned
   a_waddr_aligned: assert property (
      @(posedge clk_i) disable iff (reset_i)
      cke_i && valid_i |=> (wr.waddr % STRB_W) == 0
   );

endmodule

/* hw/regbank_2p.sv */
`timescale 1ns/1ps

// byte register file
// write side takes one byte per request, picked by the lowest strobe bit
// read side returns RD_REGS consecutive registers, no latency
module regbank_2p
   import regbank_cfg_pkg::*;
   import cpu_bus_pkg::*;
(
   input  logic     clk_i,
   input  logic     reset_i,
   input  logic     cke_i,
   regbank_wr_if.sink wr,
   input  reg_idx_t raddr_i,
   output rdata_t   resp_o
);

   reg_byte_t        regs [REG_N];  // the register array
   lane_t            lane;          // offset of the first strobed byte
   logic [WADDR_W:0] tgt;           // target index, one extra bit for overflow
   reg_byte_t        wbyte;         // byte lane selected for the write
   logic [REG_N-1:0] reg_en;        // one-hot register enable

   strb_offset u_strb_offset (
      .data_i  (wr.wstrb),
      .count_o (lane)
   );

   // word address plus lane offset
   assign tgt = {1'b0, wr.waddr} + (WADDR_W + 1)'(lane);

   // pick the data lane that matches the offset
   always_comb begin
      wbyte = '0;
      for (int j = 0; j < STRB_W; j++) begin
         if (lane == lane_t'(j)) begin
            wbyte = wr.wdata[j*REG_W +: REG_W];
         end
      end
   end

   // enable exactly one register, or none when the request is dropped
   always_comb begin
      reg_en = '0;
      if (wr.wen && (lane < lane_t'(STRB_W)) && (tgt < REG_N)) begin
         reg_en[tgt[RADDR_W-1:0]] = 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         for (int i = 0; i < REG_N; i++) begin
            regs[i] <= '0;
         end
      end else if (cke_i) begin
         for (int i = 0; i < REG_N; i++) begin
            if (reg_en[i]) begin
               regs[i] <= wbyte;
            end
         end
      end
   end

   // read window
   // register raddr in the low byte, higher registers above it
   always_comb begin
      for (int k = 0; k < RD_REGS; k++) begin
         resp_o[k*REG_W +: REG_W] = regs[raddr_i + reg_idx_t'(k)];
      end
   end

   // read window must not run past the last register
   a_raddr_range: assert property (
      @(posedge clk_i) disable iff (reset_i)
      raddr_i <= reg_idx_t'(REG_N - RD_REGS)
   );

   // the cpu port never forwards an empty strobe
   a_wstrb_nonzero: assert property (
      @(posedge clk_i) disable iff (reset_i)
      wr.wen |-> wr.wstrb != '0
   );

endmodule

/* hw/regbank_cfg_pkg.sv */
package regbank_cfg_pkg;

   // register file geometry
   localparam int REG_N   = 16;             // byte registers in the bank
   localparam int REG_W   = 8;              // bits per register
   localparam int RADDR_W = $clog2(REG_N);  // register index width

   // core-side read window
   localparam int RD_REGS = 4;              // consecutive registers per read
   localparam int RDATA_W = RD_REGS * REG_W;

   // index of one register, also the read start index
   typedef logic [RADDR_W-1:0] reg_idx_t;

   // contents of one register
   typedef logic [REG_W-1:0] reg_byte_t;

   // read word, register raddr in the low byte,
   // raddr+1 above it and so on up to raddr+RD_REGS-1
   typedef logic [RDATA_W-1:0] rdata_t;

endpackage

/* hw/regbank_top.sv */
`timescale 1ns/1ps

// register bank top
// cpu write strobes in, core read window out
module regbank_top
   import regbank_cfg_pkg::*;
   import cpu_bus_pkg::*;
(
   input  logic     clk_i,
   input  logic     reset_i,
   input  logic     cke_i,
   // cpu write side
   input  logic     cpu_valid_i,
   input  waddr_t   cpu_addr_i,
   input  wdata_t   cpu_wdata_i,
   input  wstrb_t   cpu_wstrb_i,
   output logic     cpu_ack_o,
   // core read side
   input  reg_idx_t raddr_i,
   output rdata_t   rdata_o
);

   regbank_wr_if wr_if ();  // registered request between the two blocks

   cpu_wr_port u_wr_port (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .cke_i   (cke_i),
      .valid_i (cpu_valid_i),
      .addr_i  (cpu_addr_i),
      .wdata_i (cpu_wdata_i),
      .wstrb_i (cpu_wstrb_i),
      .ack_o   (cpu_ack_o),
      .wr      (wr_if.source)
   );

   regbank_2p u_regbank (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .cke_i   (cke_i),
      .wr      (wr_if.sink),
      .raddr_i (raddr_i),
      .resp_o  (rdata_o)
   );

endmodule

/* hw/regbank_wr_if.sv */
`timescale 1ns/1ps

// one registered write request, cpu port to register bank
interface regbank_wr_if
   import cpu_bus_pkg::*;
();

   logic   wen;    // request present this cycle
   waddr_t waddr;  // word aligned byte address
   wstrb_t wstrb;  // byte lane strobe
   wdata_t wdata;  // full write word, lanes picked by the sink

   // request register side
   modport source (
      output wen,
      output waddr,
      output wstrb,
      output wdata
   );

   // register file side
   modport sink (
      input wen,
      input waddr,
      input wstrb,
      input wdata
   );

endinterface

/* hw/strb_offset.sv */
`timescale 1ns/1ps

// trailing zero count of a byte strobe
// gives the lane of the lowest enabled byte, STRB_W when none is set
module strb_offset
   import cpu_bus_pkg::*;
(
   input  wstrb_t data_i,
   output lane_t  count_o
);

   lane_t count;

   always_comb begin
      count = lane_t'(STRB_W);  // empty strobe
      // scan from the top so the lowest set bit wins
      for (int i = STRB_W - 1; i >= 0; i--) begin
         if (data_i[i]) begin
            count = lane_t'(i);
         end
      end
   end

   assign count_o = count;

endmodule
